// ==== fetch_unit.f ====
src/wb_pkg.sv
src/fetch_pkg.sv
src/fetch_handshake.sv
src/burst_fetch.sv
src/sample_ram.sv
src/block_buffer.sv
src/fetch_top.sv
testbench/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module fetch_tb \
   -f fetch_unit.f \
   -o fetch_sim

# The simulator exits nonzero on any failing check or timeout
./obj_dir/fetch_sim

// ==== src/block_buffer.sv ====
`timescale 1ns/1ps

// Block buffer, words stored in ack order, host reads by index
module block_buffer import fetch_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    clear_i,   // New block, restart at index 0
   input  logic    wr_i,      // One word per bus ack
   input  sample_t wr_dat_i,
   input  fidx_t   rd_idx_i,
   output sample_t rd_dat_o   // One cycle after rd_idx_i
);

   sample_t words [FETCH_WORDS];  // Old block stays until overwritten
   fidx_t   wr_idx;

   // ----------------------------------------
   // Write side
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_idx <= '0;
      end else if (clear_i) begin
         wr_idx <= '0;
      end else if (wr_i && wr_idx != fidx_t'(FETCH_WORDS - 1)) begin
         wr_idx <= wr_idx + 1'b1;  // Holds at the last entry
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_i && !clear_i)
         words[wr_idx] <= wr_dat_i;
   end

   // ----------------------------------------
   // Host read side
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rd_idx_i < fidx_t'(FETCH_WORDS))
         rd_dat_o <= words[rd_idx_i];
      else
         rd_dat_o <= '0;  // Past the block end
   end

endmodule

// ==== src/burst_fetch.sv ====
`timescale 1ns/1ps

// Pipelined Wishbone burst read master, FETCH_WORDS words per block
module burst_fetch import wb_pkg::*, fetch_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    start_i,  // Begin a block, one-cycle pulse
   input  wb_adr_t base_i,   // First word of the block
   output logic    cyc_o,
   output logic    stb_o,
   output wb_adr_t adr_o,
   input  logic    stall_i,
   input  logic    ack_i,
   output logic    done_o    // Block complete, one-cycle pulse
);

   wb_adr_t           base_q;    // Base latched at start
   fidx_t             idx;       // Index of the current command
   logic [QCNT_W-1:0] qcnt;      // Commands issued, not yet acked
   logic              accept;    // Strobe taken by the slave
   logic              last_idx;  // Final command of the block
   logic              cyc_end;   // Last outstanding ack arrives
   logic              cyc_d;     // cyc_o one cycle late

   assign accept   = stb_o && !stall_i;
   assign last_idx = (idx == fidx_t'(FETCH_WORDS - 1));
   assign adr_o    = base_q + wb_adr_t'(idx);  // Wraps within the RAM

   // All commands out, one left in flight and its ack here
   assign cyc_end  = cyc_o && !stb_o && ack_i && (qcnt == QCNT_W'(1));

   // ----------------------------------------
   // Bus control
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_o <= 1'b0;
         stb_o <= 1'b0;
      end else if (start_i) begin
         cyc_o <= 1'b1;
         stb_o <= 1'b1;
      end else begin
         if (accept && last_idx)
            stb_o <= 1'b0;  // Held while stalled, dropped after last
         if (cyc_end)
            cyc_o <= 1'b0;
      end
   end

   // ----------------------------------------
   // Address counter
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         idx <= '0;
      end else if (start_i) begin
         idx <= '0;
      end else if (accept && !last_idx) begin
         idx <= idx + 1'b1;  // Stops at the last word
      end
   end

   // Base only matters while cyc_o is high
   always_ff @(posedge clk_i) begin
      if (start_i)
         base_q <= base_i;
   end

   // ----------------------------------------
   // Outstanding commands
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || start_i) begin
         qcnt <= '0;  // Empty at block start
      end else begin
         case ({accept, ack_i && cyc_o})
            2'b10:   qcnt <= qcnt + 1'b1;  // Issued
            2'b01:   qcnt <= qcnt - 1'b1;  // Completed
            default: qcnt <= qcnt;         // Both or neither
         endcase
      end
   end

   // ----------------------------------------
   // Completion
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_d  <= 1'b0;
         done_o <= 1'b0;
      end else begin
         cyc_d  <= cyc_o;
         done_o <= cyc_d && !cyc_o;  // One cycle after cyc_o falls
      end
   end

endmodule

// ==== src/fetch_handshake.sv ====
`timescale 1ns/1ps

// Four-phase req/ack front end, one start pulse per request
module fetch_handshake (
   input  logic clk_i,
   input  logic rst_i,
   input  logic req_i,    // Host request level
   input  logic done_i,   // Block fetched, one-cycle pulse
   output logic ack_o,
   output logic start_o,  // Fetch start, one-cycle pulse
   output logic busy_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_ACKED} hs_state_t;

   hs_state_t state;
   logic      req_q;  // Previous req_i, for the rising edge

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= ST_IDLE;
         req_q   <= 1'b0;
         start_o <= 1'b0;
      end else begin
         req_q   <= req_i;
         start_o <= 1'b0;  // Default, pulse only
         case (state)
            ST_IDLE: if (req_i && !req_q) begin  // New request only
               start_o <= 1'b1;
               state   <= ST_FETCH;
            end
            ST_FETCH: if (done_i) state <= ST_ACKED;
            ST_ACKED: if (!req_i) state <= ST_IDLE;  // Host withdrew req
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign ack_o  = (state == ST_ACKED);  // Held until req_i falls
   assign busy_o = (state == ST_FETCH);

endmodule

// ==== src/fetch_pkg.sv ====
// Block geometry and counters of the fetch unit

package fetch_pkg;

   import wb_pkg::*;

   localparam int FETCH_WORDS = 24;  // Samples per block
   localparam int FCNT_W      = 5;   // Index 0..23

   // Commands in flight, up to RD_LATENCY+1 with latency 2
   localparam int QCNT_W      = 2;

   typedef logic [FCNT_W-1:0] fidx_t;  // Block index

   // A sample is one bus word
   typedef wb_dat_t sample_t;

endpackage

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

// Block-fetch unit, handshake, bus master, sample RAM and buffer
module fetch_top import wb_pkg::*, fetch_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   // Host write into the sample RAM
   input  logic    wr_en_i,
   input  wb_adr_t wr_adr_i,
   input  wb_dat_t wr_dat_i,
   // Four-phase fetch request
   input  logic    req_i,
   input  wb_adr_t base_i,
   output logic    ack_o,
   output logic    busy_o,
   // Buffer read port
   input  fidx_t   rd_idx_i,
   output sample_t rd_dat_o
);

   logic    fetch_start;  // Also clears the buffer write index
   logic    fetch_done;

   // Internal Wishbone bus
   logic    wb_cyc;
   logic    wb_stb;
   wb_adr_t wb_adr;
   logic    wb_stall;
   logic    wb_ack;
   wb_dat_t wb_dat;

   fetch_handshake u_handshake (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (req_i),
      .done_i  (fetch_done),
      .ack_o   (ack_o),
      .start_o (fetch_start),
      .busy_o  (busy_o)
   );

   burst_fetch u_fetch (
      .clk_i (clk_i), .rst_i (rst_i),
      .start_i (fetch_start), .base_i (base_i),
      .cyc_o (wb_cyc), .stb_o (wb_stb), .adr_o (wb_adr),
      .stall_i (wb_stall), .ack_i (wb_ack), .done_o (fetch_done)
   );

   sample_ram u_ram (
      .clk_i (clk_i), .rst_i (rst_i),
      .wr_en_i (wr_en_i), .wr_adr_i (wr_adr_i), .wr_dat_i (wr_dat_i),
      .cyc_i (wb_cyc), .stb_i (wb_stb), .adr_i (wb_adr),
      .stall_o (wb_stall), .ack_o (wb_ack), .dat_o (wb_dat)
   );

   block_buffer u_buffer (
      .clk_i (clk_i), .rst_i (rst_i),
      .clear_i (fetch_start), .wr_i (wb_ack), .wr_dat_i (wb_dat),
      .rd_idx_i (rd_idx_i), .rd_dat_o (rd_dat_o)
   );

endmodule

// ==== src/sample_ram.sv ====
`timescale 1ns/1ps

// Sample memory with a host write port and a pipelined Wishbone read slave
module sample_ram import wb_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   // Host write port
   input  logic    wr_en_i,
   input  wb_adr_t wr_adr_i,
   input  wb_dat_t wr_dat_i,
   // Wishbone slave, read only
   input  logic    cyc_i,
   input  logic    stb_i,
   input  wb_adr_t adr_i,
   output logic    stall_o,
   output logic    ack_o,
   output wb_dat_t dat_o
);

   wb_dat_t                 mem [2**WB_ADR_W];
   logic [RD_LATENCY-1:0]   rd_vld;          // Read in flight per stage
   wb_dat_t                 rd_dat [RD_LATENCY];
   logic                    rd_take;         // Strobe accepted this cycle

   // Host write wins the single port and the strobe waits
   assign stall_o = wr_en_i && cyc_i && stb_i;
   assign rd_take = cyc_i && stb_i && !stall_o;

   // ----------------------------------------
   // Memory array and read data pipeline
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_en_i)
         mem[wr_adr_i] <= wr_dat_i;
      if (rd_take)
         rd_dat[0] <= mem[adr_i];  // First read stage
      for (int i = 1; i < RD_LATENCY; i++)
         rd_dat[i] <= rd_dat[i-1];  // Data shifts with its valid
   end

   // ----------------------------------------
   // Read valid pipeline
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_vld <= '0;
      end else begin
         rd_vld[0] <= rd_take;
         for (int i = 1; i < RD_LATENCY; i++)
            rd_vld[i] <= rd_vld[i-1];
      end
   end

   // Ack exactly RD_LATENCY cycles after acceptance
   assign ack_o = rd_vld[RD_LATENCY-1] && cyc_i;  // No ack outside a cycle
   assign dat_o = rd_dat[RD_LATENCY-1];

endmodule

// ==== src/wb_pkg.sv ====
// Internal Wishbone B4 bus between fetch master and sample RAM

package wb_pkg;

   localparam int WB_ADR_W   = 7;   // 128-word sample RAM
   localparam int WB_DAT_W   = 16;  // One sample per bus word

   // Accepted strobe to ack, fixed in the RAM slave
   localparam int RD_LATENCY = 2;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;  // Word address
   typedef logic [WB_DAT_W-1:0] wb_dat_t;  // Read data word

endpackage

// ==== testbench/fetch_stimulus.txt ====
# W addr data | F base mode | C index expected, all fields hex
# F mode: 0 plain, 1 host writes stall the bus, 2 req held while the RAM changes
W 00 1234
W 05 beef
W 17 0f0f
F 00 0
C 00 1234
C 01 817e
C 05 beef
C 0a 8a75
C 16 9669
C 17 0f0f
W 2c cafe
F 28 1
C 00 a857
C 04 cafe
C 0b b34c
C 17 bf40
F 46 2
C 00 c639
C 09 cf30
C 17 dd22

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ps

// Testbench for the block-fetch unit driven by the stimulus file
module fetch_tb import wb_pkg::*, fetch_pkg::*; ();

   localparam int          TIMEOUT_CYCLES = 200;  // Per wait loop
   localparam int          HOLD_CYCLES    = 6;    // req_i held after ack_o
   localparam int unsigned SEED           = 32'h685d_c2d0;
   localparam string       STIM_FILE      = "testbench/fetch_stimulus.txt";

   logic    clk_i;
   logic    rst_i;
   logic    wr_en_i;
   wb_adr_t wr_adr_i;
   wb_dat_t wr_dat_i;
   logic    req_i;
   wb_adr_t base_i;
   logic    ack_o;
   logic    busy_o;
   fidx_t   rd_idx_i;
   sample_t rd_dat_o;

   sample_t ram_model [2**WB_ADR_W];  // Host view of the sample RAM
   sample_t block_ref [FETCH_WORDS];  // RAM words when the last fetch began

   fetch_top DUT (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (wr_en_i),
      .wr_adr_i (wr_adr_i),
      .wr_dat_i (wr_dat_i),
      .req_i    (req_i),
      .base_i   (base_i),
      .ack_o    (ack_o),
      .busy_o   (busy_o),
      .rd_idx_i (rd_idx_i),
      .rd_dat_o (rd_dat_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;  // 40 ns period
   end

   // ----------------------------------------
   // Error path and compare tasks
   // ----------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp)
         abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
   endtask

   // Preload pattern with the whole address in both halves
   function automatic sample_t fill_word(input wb_adr_t a);
      return {1'b1, a, 1'b0, ~a};
   endfunction

   function automatic logic in_block(input wb_adr_t a, input wb_adr_t base);
      wb_adr_t off;
      off = a - base;  // Wraps like the RAM address
      return (int'(off) < FETCH_WORDS);
   endfunction

   // ----------------------------------------
   // Host side tasks
   // ----------------------------------------
   task automatic host_write(input wb_adr_t a, input sample_t d);
      @(posedge clk_i);
      wr_en_i  <= 1'b1;
      wr_adr_i <= a;
      wr_dat_i <= d;
      ram_model[a] = d;
      @(posedge clk_i);
      wr_en_i  <= 1'b0;
   endtask

   task automatic read_index(input fidx_t idx, output sample_t dat);
      @(posedge clk_i);
      rd_idx_i <= idx;
      @(posedge clk_i);  // Registered read port
      @(negedge clk_i);
      dat = rd_dat_o;
   endtask

   // Mode 0 is plain, mode 1 adds colliding host writes and mode 2 holds req_i
   task automatic run_fetch(input wb_adr_t base, input int mode);
      int      cycles;
      int      stall_writes;
      wb_adr_t wa;
      sample_t wd;
      for (int i = 0; i < FETCH_WORDS; i++)
         block_ref[i] = ram_model[base + wb_adr_t'(i)];
      cycles       = 0;
      stall_writes = 0;
      @(posedge clk_i);
      req_i  <= 1'b1;
      base_i <= base;  // Stable for the whole request
      @(negedge clk_i);
      while (ack_o !== 1'b1) begin
         @(posedge clk_i);
         wr_en_i <= 1'b0;
         if (mode == 1 && ($urandom % 3) == 0) begin
            wa = wb_adr_t'(7'h60 + ($urandom % 32));  // Upper quarter of the RAM
            wd = sample_t'($urandom);
            if (!in_block(wa, base)) begin
               wr_en_i  <= 1'b1;  // Stalls any strobe in this cycle
               wr_adr_i <= wa;
               wr_dat_i <= wd;
               ram_model[wa] = wd;
               stall_writes++;
            end
         end
         @(negedge clk_i);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_run("Timeout: ack_o never rose after the fetch request");
         if (ack_o !== 1'b1)
            check_bit("busy_o during the fetch", 1'b1, busy_o);
      end
      check_bit("busy_o with ack_o high", 1'b0, busy_o);
      if (mode == 1 && stall_writes == 0)
         abort_run("No host write was issued during the fetch, so nothing stalled");
      if (mode == 2) begin
         for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk_i);
            wr_en_i <= 1'b0;
            if (i == 1) begin
               wr_en_i  <= 1'b1;  // Block word changes after the fetch
               wr_adr_i <= base;
               wr_dat_i <= ~ram_model[base];
               ram_model[base] = ~ram_model[base];
            end
            @(negedge clk_i);
            check_bit("ack_o while req_i held", 1'b1, ack_o);
            check_bit("busy_o while req_i held", 1'b0, busy_o);  // No second fetch
         end
      end
      @(posedge clk_i);
      req_i   <= 1'b0;
      wr_en_i <= 1'b0;
      @(negedge clk_i);
      check_bit("ack_o before req_i fall is seen", 1'b1, ack_o);
      cycles = 0;
      while (ack_o !== 1'b0) begin
         @(negedge clk_i);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_run("Timeout: ack_o stayed high after req_i fell");
      end
   endtask

   task automatic verify_block(input wb_adr_t base);
      sample_t dat;
      for (int i = 0; i < FETCH_WORDS; i++) begin
         read_index(fidx_t'(i), dat);
         check_sample($sformatf("block %h index %0d", base, i), block_ref[i], dat);
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      int          fd;
      int          n;
      int unsigned f1;
      int unsigned f2;
      string       line;
      sample_t     dat;
      void'($urandom(SEED));
      rst_i    = 1'b1;
      wr_en_i  = 1'b0;
      wr_adr_i = '0;
      wr_dat_i = '0;
      req_i    = 1'b0;
      base_i   = '0;
      rd_idx_i = '0;
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      check_bit("ack_o after reset", 1'b0, ack_o);
      check_bit("busy_o after reset", 1'b0, busy_o);
      for (int a = 0; a < 2**WB_ADR_W; a++)
         host_write(wb_adr_t'(a), fill_word(wb_adr_t'(a)));
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
         abort_run("Could not open the stimulus file");
      while ($fgets(line, fd) > 0) begin
         if (line.len() < 2 || line[0] == "#")
            continue;  // Blank or column notes
         n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
         if (n != 2)
            abort_run($sformatf("Malformed stimulus line: %s", line));
         case (line[0])
            "W": host_write(wb_adr_t'(f1), sample_t'(f2));
            "F": begin
               run_fetch(wb_adr_t'(f1), int'(f2));
               verify_block(wb_adr_t'(f1));  // Every index against the model
            end
            "C": begin
               if (f1 >= FETCH_WORDS)
                  abort_run("Stimulus index lies past the end of the block");
               check_sample($sformatf("stimulus entry %0d vs model", f1),
                            block_ref[f1], sample_t'(f2));
               read_index(fidx_t'(f1), dat);
               check_sample($sformatf("buffer index %0d", f1), sample_t'(f2), dat);
            end
            default: abort_run($sformatf("Unknown stimulus command: %s", line));
         endcase
         repeat ($urandom % 4) @(posedge clk_i);  // Random gap
      end
      $fclose(fd);
      $display("Test OK");
      $finish;
   end

endmodule
